// ==== Bender.yml ====
package:
  name: flow_control

sources:
  - design/flow_ctrl_pkg.sv
  - design/flow_cfg_apb.sv
  - design/sync_marker_encoder.sv
  - design/throttle_buffer.sv
  - design/pixel_pipe.sv
  - design/stream_output_stage.sv
  - design/flow_control_top.sv
  - target: test
    files:
      - tests/flow_control_tb.sv

// ==== design/flow_cfg_apb.sv ====
// APB configuration registers
module flow_cfg_apb (
    input  logic                      pixel_clk_i,
    input  logic                      pixel_reset_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [7:0]                paddr_i,
    input  logic [31:0]               pwdata_i,
    input  logic                      overflow_pulse_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output flow_ctrl_pkg::ppc_code_t  ppc_code_o,
    output flow_ctrl_pkg::data_type_t data_type_o
);

    logic access;
    logic ctrl_sel;
    logic status_sel;
    logic overflow_q;

    assign access     = psel_i & penable_i;                  // Access phase
    assign ctrl_sel   = paddr_i == flow_ctrl_pkg::CTRL_ADDR;
    assign status_sel = paddr_i == flow_ctrl_pkg::STATUS_ADDR;

    assign pready_o  = 1'b1;                                 // No wait states
    assign pslverr_o = access & ~ctrl_sel & ~status_sel;

    always_comb begin
        prdata_o = '0;
        if (ctrl_sel) begin
            prdata_o[1:0]  = ppc_code_o;
            prdata_o[13:8] = data_type_o;
        end else if (status_sel) begin
            prdata_o[0] = overflow_q;
        end
    end

    always_ff @(posedge pixel_clk_i or negedge pixel_reset_n_i) begin
        if (!pixel_reset_n_i) begin
            ppc_code_o  <= '0;
            data_type_o <= '0;
        end else if (access && pwrite_i && ctrl_sel) begin
            ppc_code_o  <= pwdata_i[1:0];
            data_type_o <= pwdata_i[13:8];
        end
    end

    // Sticky overflow bit cleared by writing 1
    always_ff @(posedge pixel_clk_i or negedge pixel_reset_n_i) begin
        if (!pixel_reset_n_i) begin
            overflow_q <= 1'b0;
        end else if (overflow_pulse_i) begin
            overflow_q <= 1'b1;                              // New pulse beats the clear
        end else if (access && pwrite_i && status_sel && pwdata_i[0]) begin
            overflow_q <= 1'b0;
        end
    end

endmodule

// ==== design/flow_control_top.sv ====
// Camera flow control, pixel clock side
module flow_control_top #(
    parameter int BUF_ADDR_W = 5
) (
    input  logic                                   pixel_clk_i,
    input  logic                                   pixel_reset_n_i,
    input  logic                                   psel_i,
    input  logic                                   penable_i,
    input  logic                                   pwrite_i,
    input  logic [7:0]                             paddr_i,
    input  logic [31:0]                            pwdata_i,
    input  logic                                   frame_valid_i,
    input  logic [flow_ctrl_pkg::IN_DATA_W-1:0]    byte_data_i,
    input  logic [flow_ctrl_pkg::IN_LANES-1:0]     byte_valid_i,
    input  logic                                   stream_stall_i,
    output logic [31:0]                            prdata_o,
    output logic                                   pready_o,
    output logic                                   pslverr_o,
    output logic                                   frame_valid_sync_o,
    output logic [flow_ctrl_pkg::OUT_DATA_W-1:0]   pixel_data_o,
    output logic [flow_ctrl_pkg::OUT_LANES-1:0]    pixel_valid_o,
    output logic [flow_ctrl_pkg::BYTE_VALID_W-1:0] byte_valid_o
);

    logic [flow_ctrl_pkg::ENTRY_W-1:0]                wr_entry;
    logic                                             wr_entry_we;
    logic [flow_ctrl_pkg::ENTRY_W-1:0]                rd_entry;
    logic                                             buf_empty;
    logic                                             overflow_pulse;
    logic                                             pop;
    logic                                             insert;
    logic                                             extract;
    flow_ctrl_pkg::fill_t                             fill;
    logic [2:0]                                       shift;
    flow_ctrl_pkg::ppc_code_t                         ppc_code;
    flow_ctrl_pkg::data_type_t                        data_type;
    logic [4*$bits(flow_ctrl_pkg::raw8_t)-1:0]        raw8_lanes;
    logic [4*$bits(flow_ctrl_pkg::raw10_t)-1:0]       raw10_lanes;
    logic [4*$bits(flow_ctrl_pkg::rgb888_t)-1:0]      rgb888_lanes;

    flow_cfg_apb cfg_i (
        .pixel_clk_i, .pixel_reset_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i,
        .pwdata_i, .overflow_pulse_i(overflow_pulse), .prdata_o, .pready_o, .pslverr_o,
        .ppc_code_o(ppc_code), .data_type_o(data_type)
    );

    sync_marker_encoder enc_i (
        .pixel_clk_i, .pixel_reset_n_i, .frame_valid_i, .byte_data_i, .byte_valid_i,
        .entry_o(wr_entry), .entry_we_o(wr_entry_we)
    );

    throttle_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) buf_i (
        .pixel_clk_i, .pixel_reset_n_i, .wr_data_i(wr_entry), .wr_en_i(wr_entry_we),
        .pop_i(pop), .rd_data_o(rd_entry), .empty_o(buf_empty),
        .overflow_pulse_o(overflow_pulse)
    );

    // One pipe per supported pixel type
    pixel_pipe #(.PIXEL_T(flow_ctrl_pkg::raw8_t)) raw8_pipe_i (
        .pixel_clk_i, .pixel_reset_n_i, .insert_i(insert), .extract_i(extract),
        .fill_i(fill), .shift_i(shift),
        .in_data_i(rd_entry[flow_ctrl_pkg::ENTRY_W-1:flow_ctrl_pkg::IN_LANES]),
        .in_valid_i(rd_entry[flow_ctrl_pkg::IN_LANES-1:0]), .lanes_o(raw8_lanes)
    );

    pixel_pipe #(.PIXEL_T(flow_ctrl_pkg::raw10_t)) raw10_pipe_i (
        .pixel_clk_i, .pixel_reset_n_i, .insert_i(insert), .extract_i(extract),
        .fill_i(fill), .shift_i(shift),
        .in_data_i(rd_entry[flow_ctrl_pkg::ENTRY_W-1:flow_ctrl_pkg::IN_LANES]),
        .in_valid_i(rd_entry[flow_ctrl_pkg::IN_LANES-1:0]), .lanes_o(raw10_lanes)
    );

    pixel_pipe #(.PIXEL_T(flow_ctrl_pkg::rgb888_t)) rgb888_pipe_i (
        .pixel_clk_i, .pixel_reset_n_i, .insert_i(insert), .extract_i(extract),
        .fill_i(fill), .shift_i(shift),
        .in_data_i(rd_entry[flow_ctrl_pkg::ENTRY_W-1:flow_ctrl_pkg::IN_LANES]),
        .in_valid_i(rd_entry[flow_ctrl_pkg::IN_LANES-1:0]), .lanes_o(rgb888_lanes)
    );

    stream_output_stage out_i (
        .pixel_clk_i, .pixel_reset_n_i, .stream_stall_i, .empty_i(buf_empty),
        .entry_i(rd_entry), .ppc_code_i(ppc_code), .data_type_i(data_type),
        .raw8_lanes_i(raw8_lanes), .raw10_lanes_i(raw10_lanes),
        .rgb888_lanes_i(rgb888_lanes), .pop_o(pop), .insert_o(insert),
        .extract_o(extract), .fill_o(fill), .shift_o(shift), .frame_valid_sync_o,
        .pixel_data_o, .pixel_valid_o, .byte_valid_o
    );

endmodule

// ==== design/flow_ctrl_pkg.sv ====
// Flow control shared definitions
package flow_ctrl_pkg;

    // Stream widths
    localparam int IN_DATA_W    = 48;            // Two RGB888 or four RAW pixels
    localparam int IN_LANES     = 4;
    localparam int ENTRY_W      = IN_DATA_W + IN_LANES;
    localparam int OUT_DATA_W   = 96;            // Four RGB888 pixels
    localparam int OUT_LANES    = 4;
    localparam int BYTE_VALID_W = 12;
    localparam int PIPE_SLOTS   = 8;

    // MIPI CSI-2 data type codes
    typedef logic [5:0] data_type_t;

    localparam data_type_t DT_RAW8   = 6'h2A;
    localparam data_type_t DT_RAW10  = 6'h2B;
    localparam data_type_t DT_RGB888 = 6'h24;

    // Code 0 is one pixel, 1 is two, 2 and 3 are four
    typedef logic [1:0] ppc_code_t;

    typedef logic [7:0]  raw8_t;
    typedef logic [9:0]  raw10_t;
    typedef logic [23:0] rgb888_t;

    typedef logic [3:0] fill_t;                  // Pixels held in a pipe

    // APB register map
    localparam logic [7:0] CTRL_ADDR   = 8'h0;
    localparam logic [7:0] STATUS_ADDR = 8'h4;

endpackage

// ==== design/pixel_pipe.sv ====
// Pixel pipe for one pixel type
module pixel_pipe #(
    parameter type PIXEL_T = flow_ctrl_pkg::raw8_t
) (
    input  logic                                              pixel_clk_i,
    input  logic                                              pixel_reset_n_i,
    input  logic                                              insert_i,
    input  logic                                              extract_i,
    input  flow_ctrl_pkg::fill_t                              fill_i,
    input  logic [2:0]                                        shift_i,
    input  logic [flow_ctrl_pkg::IN_DATA_W-1:0]               in_data_i,
    input  logic [flow_ctrl_pkg::IN_LANES-1:0]                in_valid_i,
    output logic [flow_ctrl_pkg::OUT_LANES*$bits(PIXEL_T)-1:0] lanes_o
);

    localparam int PIX_W     = $bits(PIXEL_T);
    localparam int SLOTS     = flow_ctrl_pkg::PIPE_SLOTS;
    localparam int WIDE_FIT  = flow_ctrl_pkg::IN_DATA_W / PIX_W;
    // Input slots that lie fully inside the input word
    localparam int FIT_LANES = (WIDE_FIT < flow_ctrl_pkg::IN_LANES) ?
                               WIDE_FIT : flow_ctrl_pkg::IN_LANES;

    PIXEL_T slots_q [SLOTS];
    PIXEL_T slots_d [SLOTS];

    always_comb begin
        int pos;
        slots_d = slots_q;
        if (extract_i) begin
            for (int j = 0; j < SLOTS; j++) begin
                slots_d[j] = (j + shift_i < SLOTS) ? slots_q[j + shift_i] : '0;
            end
        end
        // Fill already accounts for this cycle's extract
        pos = fill_i;
        if (insert_i) begin
            for (int i = 0; i < FIT_LANES; i++) begin
                if (in_valid_i[i] && pos < SLOTS) begin
                    slots_d[pos] = in_data_i[i*PIX_W +: PIX_W];
                    pos++;                                   // Valid pixels pack in order
                end
            end
        end
    end

    always_ff @(posedge pixel_clk_i or negedge pixel_reset_n_i) begin
        if (!pixel_reset_n_i) begin
            slots_q <= '{default: '0};
        end else begin
            slots_q <= slots_d;
        end
    end

    // Oldest pixels go out on the low lanes
    always_comb begin
        for (int k = 0; k < flow_ctrl_pkg::OUT_LANES; k++) begin
            lanes_o[k*PIX_W +: PIX_W] = slots_q[k];
        end
    end

endmodule

// ==== design/stream_output_stage.sv ====
// Output repacking stage
module stream_output_stage (
    input  logic                                   pixel_clk_i,
    input  logic                                   pixel_reset_n_i,
    input  logic                                   stream_stall_i,
    input  logic                                   empty_i,
    input  logic [flow_ctrl_pkg::ENTRY_W-1:0]      entry_i,
    input  flow_ctrl_pkg::ppc_code_t               ppc_code_i,
    input  flow_ctrl_pkg::data_type_t              data_type_i,
    input  logic [4*$bits(flow_ctrl_pkg::raw8_t)-1:0]   raw8_lanes_i,
    input  logic [4*$bits(flow_ctrl_pkg::raw10_t)-1:0]  raw10_lanes_i,
    input  logic [4*$bits(flow_ctrl_pkg::rgb888_t)-1:0] rgb888_lanes_i,
    output logic                                   pop_o,
    output logic                                   insert_o,
    output logic                                   extract_o,
    output flow_ctrl_pkg::fill_t                   fill_o,
    output logic [2:0]                             shift_o,
    output logic                                   frame_valid_sync_o,
    output logic [flow_ctrl_pkg::OUT_DATA_W-1:0]   pixel_data_o,
    output logic [flow_ctrl_pkg::OUT_LANES-1:0]    pixel_valid_o,
    output logic [flow_ctrl_pkg::BYTE_VALID_W-1:0] byte_valid_o
);

    localparam flow_ctrl_pkg::fill_t POP_LIMIT =
        flow_ctrl_pkg::fill_t'(flow_ctrl_pkg::PIPE_SLOTS - flow_ctrl_pkg::IN_LANES);

    logic                                 entry_valid_q;   // Popped entry on entry_i
    logic                                 in_frame_q;
    flow_ctrl_pkg::fill_t                 fill_q;
    flow_ctrl_pkg::fill_t                 fill_next;
    flow_ctrl_pkg::fill_t                 ppc_fill;
    flow_ctrl_pkg::fill_t                 insert_cnt;
    logic [flow_ctrl_pkg::IN_LANES-1:0]   mask;
    logic [flow_ctrl_pkg::IN_LANES-1:0]   fit_mask;
    logic                                 is_start;
    logic                                 is_end;
    logic                                 type_ok;
    logic [1:0]                           bytes_pp;
    logic [3:0]                           n_bytes;
    logic [flow_ctrl_pkg::OUT_DATA_W-1:0] lanes_mux;

    assign mask = entry_i[flow_ctrl_pkg::IN_LANES-1:0];

    // A full mask only counts as a start marker outside a frame
    assign is_start = entry_valid_q & ~in_frame_q & (&mask) &
                      (entry_i[flow_ctrl_pkg::ENTRY_W-1:flow_ctrl_pkg::IN_LANES] == '0);
    assign is_end   = entry_valid_q & (mask == '0);
    assign insert_o = entry_valid_q & in_frame_q & ~is_end;

    always_comb begin
        case (ppc_code_i)
            2'd0:    shift_o = 3'd1;
            2'd1:    shift_o = 3'd2;
            default: shift_o = 3'd4;
        endcase
    end

    assign ppc_fill = {1'b0, shift_o};

    always_comb begin
        type_ok   = 1'b1;
        fit_mask  = '1;
        bytes_pp  = 2'd1;
        lanes_mux = '0;
        case (data_type_i)
            flow_ctrl_pkg::DT_RAW8: begin
                lanes_mux[$bits(raw8_lanes_i)-1:0] = raw8_lanes_i;
            end
            flow_ctrl_pkg::DT_RAW10: begin
                bytes_pp = 2'd2;
                lanes_mux[$bits(raw10_lanes_i)-1:0] = raw10_lanes_i;
            end
            flow_ctrl_pkg::DT_RGB888: begin
                bytes_pp  = 2'd3;
                fit_mask  = 4'b0011;                         // Two pixels per input word
                lanes_mux = rgb888_lanes_i;
            end
            default: type_ok = 1'b0;
        endcase
    end

    assign n_bytes = {1'b0, shift_o} * {2'b00, bytes_pp};

    always_comb begin
        insert_cnt = '0;
        for (int i = 0; i < flow_ctrl_pkg::IN_LANES; i++) begin
            insert_cnt = insert_cnt + {3'b000, mask[i] & fit_mask[i]};
        end
    end

    // Occupancy bookkeeping
    assign extract_o = ~stream_stall_i & (fill_q >= ppc_fill);
    assign fill_o    = extract_o ? fill_q - ppc_fill : fill_q;
    assign fill_next = is_end ? '0 : (insert_o ? fill_o + insert_cnt : fill_o);
    assign pop_o     = ~empty_i & ~stream_stall_i & (fill_next <= POP_LIMIT);

    always_ff @(posedge pixel_clk_i or negedge pixel_reset_n_i) begin
        if (!pixel_reset_n_i) begin
            entry_valid_q      <= 1'b0;
            in_frame_q         <= 1'b0;
            fill_q             <= '0;
            frame_valid_sync_o <= 1'b0;
            pixel_valid_o      <= '0;
            byte_valid_o       <= '0;
        end else begin
            entry_valid_q <= pop_o;                          // Read data lands next cycle
            fill_q        <= fill_next;                      // Residue dropped at frame end
            if (is_start) begin
                in_frame_q <= 1'b1;
            end else if (is_end) begin
                in_frame_q <= 1'b0;
            end
            if (!stream_stall_i) begin
                frame_valid_sync_o <= in_frame_q | is_start; // Covers the last beat
                pixel_valid_o <= (extract_o && type_ok) ? ~(4'hF << shift_o) : '0;
                byte_valid_o  <= (extract_o && type_ok) ? ~(12'hFFF << n_bytes) : '0;
            end
        end
    end

    always_ff @(posedge pixel_clk_i) begin
        if (!stream_stall_i) begin
            pixel_data_o <= lanes_mux;
        end
    end

endmodule

// ==== design/sync_marker_encoder.sv ====
// Frame marker encoder
module sync_marker_encoder (
    input  logic                                pixel_clk_i,
    input  logic                                pixel_reset_n_i,
    input  logic                                frame_valid_i,
    input  logic [flow_ctrl_pkg::IN_DATA_W-1:0] byte_data_i,
    input  logic [flow_ctrl_pkg::IN_LANES-1:0]  byte_valid_i,
    output logic [flow_ctrl_pkg::ENTRY_W-1:0]   entry_o,
    output logic                                entry_we_o
);

    logic frame_valid_q;
    logic fv_rise;
    logic fv_fall;

    always_ff @(posedge pixel_clk_i or negedge pixel_reset_n_i) begin
        if (!pixel_reset_n_i) begin
            frame_valid_q <= 1'b0;
        end else begin
            frame_valid_q <= frame_valid_i;
        end
    end

    assign fv_rise = frame_valid_i & ~frame_valid_q;
    assign fv_fall = ~frame_valid_i & frame_valid_q;

    // Entry is {data, valid mask}
    always_comb begin
        entry_o = '0;                                        // End marker has an empty mask
        if (fv_rise) begin
            entry_o[flow_ctrl_pkg::IN_LANES-1:0] = '1;       // Start marker
        end else if (!fv_fall) begin
            entry_o = {byte_data_i, byte_valid_i};
        end
    end

    assign entry_we_o = fv_rise | fv_fall | (|byte_valid_i);

endmodule

// ==== design/throttle_buffer.sv ====
// Throttle buffer FIFO
module throttle_buffer #(
    parameter int BUF_ADDR_W = 5
) (
    input  logic                              pixel_clk_i,
    input  logic                              pixel_reset_n_i,
    input  logic [flow_ctrl_pkg::ENTRY_W-1:0] wr_data_i,
    input  logic                              wr_en_i,
    input  logic                              pop_i,
    output logic [flow_ctrl_pkg::ENTRY_W-1:0] rd_data_o,
    output logic                              empty_o,
    output logic                              overflow_pulse_o
);

    localparam int DEPTH = 2 ** BUF_ADDR_W;

    logic [flow_ctrl_pkg::ENTRY_W-1:0] mem [DEPTH];
    logic [BUF_ADDR_W-1:0]             wr_ptr;
    logic [BUF_ADDR_W-1:0]             rd_ptr;
    logic [BUF_ADDR_W-1:0]             used;
    logic                              full_q;
    logic                              wr_ok;

    assign used             = wr_ptr - rd_ptr;
    assign empty_o          = used == '0;
    assign wr_ok            = wr_en_i & ~full_q;
    assign overflow_pulse_o = wr_en_i & full_q;              // Entry dropped

    always_ff @(posedge pixel_clk_i or negedge pixel_reset_n_i) begin
        if (!pixel_reset_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full_q <= 1'b0;
        end else begin
            // Full lags the pointers by one cycle so it trips two entries early
            full_q <= used >= DEPTH - 2;
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Dual port RAM with registered read port
    always_ff @(posedge pixel_clk_i) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (pop_i) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

endmodule

// ==== flist.f ====
design/flow_ctrl_pkg.sv
design/flow_cfg_apb.sv
design/sync_marker_encoder.sv
design/throttle_buffer.sv
design/pixel_pipe.sv
design/stream_output_stage.sv
design/flow_control_top.sv
tests/flow_control_tb.sv

// ==== tests/flow_control_tb.sv ====
// Flow control testbench
module flow_control_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAW8_BEATS  = 16;
    localparam int RAW10_BEATS = 24;
    localparam int RGB_BEATS   = 16;
    localparam int OVF_BEATS   = 40;
    // Beats times cycles per beat, plus APB traffic and frame edges
    localparam int STIM_CYCLES = RAW8_BEATS + RAW10_BEATS * 4 + RGB_BEATS * 3 + OVF_BEATS + 100;

    logic                                   pixel_clk_i;
    logic                                   pixel_reset_n_i;
    logic                                   psel_i;
    logic                                   penable_i;
    logic                                   pwrite_i;
    logic [7:0]                             paddr_i;
    logic [31:0]                            pwdata_i;
    logic                                   frame_valid_i;
    logic [flow_ctrl_pkg::IN_DATA_W-1:0]    byte_data_i;
    logic [flow_ctrl_pkg::IN_LANES-1:0]     byte_valid_i;
    logic                                   stream_stall_i;
    logic [31:0]                            prdata_o;
    logic                                   pready_o;
    logic                                   pslverr_o;
    logic                                   frame_valid_sync_o;
    logic [flow_ctrl_pkg::OUT_DATA_W-1:0]   pixel_data_o;
    logic [flow_ctrl_pkg::OUT_LANES-1:0]    pixel_valid_o;
    logic [flow_ctrl_pkg::BYTE_VALID_W-1:0] byte_valid_o;

    logic [31:0]                            lfsr_q;
    logic                                   random_stall;
    logic [23:0]                            pix_q [$];       // Input pixels of the frame
    int                                     cur_ppc;
    int                                     cur_pix_w;
    int                                     cur_bpp;
    int                                     exp_count;
    int                                     rx_count;
    int                                     err_count;
    logic                                   hold_pending;
    logic [flow_ctrl_pkg::OUT_DATA_W-1:0]   held_data;
    logic [flow_ctrl_pkg::OUT_LANES-1:0]    held_pix;
    logic [flow_ctrl_pkg::OUT_DATA_W-1:0]   data_mask;

    flow_control_top #(.BUF_ADDR_W(5)) dut_i (
        .pixel_clk_i, .pixel_reset_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .frame_valid_i, .byte_data_i, .byte_valid_i, .stream_stall_i, .prdata_o, .pready_o,
        .pslverr_o, .frame_valid_sync_o, .pixel_data_o, .pixel_valid_o, .byte_valid_o
    );

    always #4 pixel_clk_i = ~pixel_clk_i;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        err_count++;
        abort_run($sformatf("[FAIL] %0d ns: %s", $time, msg));
    endtask

    task automatic expect_data(input logic [flow_ctrl_pkg::OUT_DATA_W-1:0] exp,
                               input logic [flow_ctrl_pkg::OUT_DATA_W-1:0] got,
                               input string what);
        if (got !== exp) begin
            value_error($sformatf("%s: pixel_data_o %h, expected %h", what, got, exp));
        end
    endtask

    task automatic expect_pix_mask(input logic [flow_ctrl_pkg::OUT_LANES-1:0] exp,
                                   input logic [flow_ctrl_pkg::OUT_LANES-1:0] got);
        if (got !== exp) begin
            value_error($sformatf("pixel_valid_o %b, expected %b", got, exp));
        end
    endtask

    task automatic expect_byte_mask(input logic [flow_ctrl_pkg::BYTE_VALID_W-1:0] exp,
                                    input logic [flow_ctrl_pkg::BYTE_VALID_W-1:0] got);
        if (got !== exp) begin
            value_error($sformatf("byte_valid_o %b, expected %b", got, exp));
        end
    endtask

    task automatic expect_sync(input logic exp, input logic got);
        if (got !== exp) begin
            value_error($sformatf("frame_valid_sync_o %b, expected %b", got, exp));
        end
    endtask

    task automatic expect_reg(input logic [31:0] exp, input logic [31:0] got, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s read %h, expected %h", what, got, exp));
        end
    endtask

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Expected beat: ppc pixels in arrival order, lane k at k times the pixel width
    function automatic logic [flow_ctrl_pkg::OUT_DATA_W-1:0] ref_beat_data(input int beat);
        logic [flow_ctrl_pkg::OUT_DATA_W-1:0] d;
        logic [flow_ctrl_pkg::OUT_DATA_W-1:0] p;
        d = '0;
        for (int k = 0; k < cur_ppc; k++) begin
            p = '0;
            p[23:0] = pix_q[beat * cur_ppc + k];
            d = d | (p << (k * cur_pix_w));
        end
        return d;
    endfunction

    function automatic logic [flow_ctrl_pkg::OUT_LANES-1:0] ref_pix_mask();
        logic [flow_ctrl_pkg::OUT_LANES-1:0] m;
        m = '0;
        for (int k = 0; k < cur_ppc; k++) begin
            m[k] = 1'b1;
        end
        return m;
    endfunction

    function automatic logic [flow_ctrl_pkg::BYTE_VALID_W-1:0] ref_byte_mask();
        logic [flow_ctrl_pkg::BYTE_VALID_W-1:0] m;
        m = '0;
        for (int k = 0; k < cur_ppc * cur_bpp; k++) begin
            m[k] = 1'b1;
        end
        return m;
    endfunction

    // Every drive happens 1 ns after the rising edge
    task automatic step_cycle();
        logic [31:0] r;
        @(posedge pixel_clk_i);
        #1;
        if (random_stall) begin
            take_bits(2, r);
            stream_stall_i = &r[1:0];                        // Stall one cycle in four
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        psel_i   = 1'b1;
        pwrite_i = 1'b1;
        paddr_i  = addr;
        pwdata_i = data;
        step_cycle();
        penable_i = 1'b1;
        step_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        psel_i   = 1'b1;
        pwrite_i = 1'b0;
        paddr_i  = addr;
        step_cycle();
        penable_i = 1'b1;
        @(negedge pixel_clk_i);                              // Access phase
        data = prdata_o;
        err  = pslverr_o;
        expect_reg(32'h1, {31'h0, pready_o}, "PREADY in access phase");
        step_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic wait_beats(input int limit);
        int n;
        n = 0;
        while (rx_count < exp_count && n < limit) begin
            step_cycle();
            n++;
        end
        if (rx_count < exp_count) begin
            abort_run($sformatf("Frame ended with %0d of %0d output beats missing",
                                exp_count - rx_count, exp_count));
        end
    endtask

    task automatic send_frame(input flow_ctrl_pkg::data_type_t dt, input logic [1:0] ppc_code,
                              input int n_beats, input int gap, input logic stall_on);
        int                                  lanes;
        int                                  n;
        logic [31:0]                         r;
        logic [flow_ctrl_pkg::IN_DATA_W-1:0] data;
        logic [flow_ctrl_pkg::IN_DATA_W-1:0] wide;
        apb_write(flow_ctrl_pkg::CTRL_ADDR, (32'(dt) << 8) | 32'(ppc_code));
        case (dt)
            flow_ctrl_pkg::DT_RAW8: begin
                lanes     = 4;
                cur_pix_w = 8;
                cur_bpp   = 1;
            end
            flow_ctrl_pkg::DT_RAW10: begin
                lanes     = 4;
                cur_pix_w = 10;
                cur_bpp   = 2;
            end
            default: begin
                lanes     = 2;
                cur_pix_w = 24;
                cur_bpp   = 3;
            end
        endcase
        cur_ppc = (ppc_code == 2'd0) ? 1 : ((ppc_code == 2'd1) ? 2 : 4);
        pix_q.delete();
        rx_count  = 0;
        exp_count = n_beats * lanes / cur_ppc;
        random_stall  = stall_on;
        frame_valid_i = 1'b1;
        step_cycle();
        for (int b = 0; b < n_beats; b++) begin
            data = '0;
            for (int i = 0; i < lanes; i++) begin
                take_bits(cur_pix_w, r);
                pix_q.push_back(r[23:0]);
                wide = '0;
                wide[23:0] = r[23:0];
                data = data | (wide << (i * cur_pix_w));
            end
            byte_data_i  = data;
            byte_valid_i = (lanes == 4) ? 4'hF : 4'h3;
            step_cycle();
            byte_valid_i = '0;
            repeat (gap) step_cycle();
        end
        wait_beats(400);
        random_stall   = 1'b0;
        stream_stall_i = 1'b0;
        frame_valid_i  = 1'b0;
        n = 0;
        while (frame_valid_sync_o !== 1'b0 && n < 16) begin
            step_cycle();
            n++;
        end
        expect_sync(1'b0, frame_valid_sync_o);
    endtask

    // Checks every transfer and the hold of a stalled beat
    always @(negedge pixel_clk_i) begin
        if (pixel_reset_n_i) begin
            if (hold_pending) begin
                expect_data(held_data, pixel_data_o, "Stalled beat changed");
                expect_pix_mask(held_pix, pixel_valid_o);
            end
            hold_pending = (pixel_valid_o != '0) && stream_stall_i;
            held_data    = pixel_data_o;
            held_pix     = pixel_valid_o;
            if ((pixel_valid_o != '0) && !stream_stall_i) begin
                if (rx_count >= exp_count) begin
                    value_error("Output beat with no input pixels left for it");
                end else begin
                    // Nothing may sit above the four lanes of the active type
                    data_mask = '1;
                    data_mask = data_mask << (flow_ctrl_pkg::OUT_LANES * cur_pix_w);
                    expect_data('0, pixel_data_o & data_mask, "Bits above the lanes");
                    data_mask = '1;
                    data_mask = ~(data_mask << (cur_ppc * cur_pix_w));
                    expect_data(ref_beat_data(rx_count), pixel_data_o & data_mask,
                                $sformatf("Beat %0d", rx_count));
                    expect_pix_mask(ref_pix_mask(), pixel_valid_o);
                    expect_byte_mask(ref_byte_mask(), byte_valid_o);
                    expect_sync(1'b1, frame_valid_sync_o);
                    rx_count++;
                end
            end
        end
    end

    initial begin
        repeat (40 * STIM_CYCLES) @(posedge pixel_clk_i);
        abort_run($sformatf("Timeout after %0d cycles, the run did not finish",
                            40 * STIM_CYCLES));
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        pixel_clk_i     = 1'b0;
        pixel_reset_n_i = 1'b0;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        paddr_i         = '0;
        pwdata_i        = '0;
        frame_valid_i   = 1'b0;
        byte_data_i     = '0;
        byte_valid_i    = '0;
        stream_stall_i  = 1'b0;
        lfsr_q          = 32'hb3a4_1f91;
        random_stall    = 1'b0;
        cur_ppc         = 1;
        cur_pix_w       = 8;
        cur_bpp         = 1;
        exp_count       = 0;
        rx_count        = 0;
        err_count       = 0;
        hold_pending    = 1'b0;
        repeat (2) @(posedge pixel_clk_i);
        #1;
        pixel_reset_n_i = 1'b1;
        expect_sync(1'b0, frame_valid_sync_o);
        expect_pix_mask('0, pixel_valid_o);
        expect_byte_mask('0, byte_valid_o);
        expect_reg(32'h0, {31'h0, pslverr_o}, "PSLVERR after reset");

        // Register access
        apb_write(flow_ctrl_pkg::CTRL_ADDR, 32'hFFFF_EB05);
        apb_read(flow_ctrl_pkg::CTRL_ADDR, rd, err);
        expect_reg(32'h0000_2B01, rd, "CTRL");
        expect_reg(32'h0, {31'h0, err}, "PSLVERR at CTRL");
        apb_read(flow_ctrl_pkg::STATUS_ADDR, rd, err);
        expect_reg(32'h0, rd, "STATUS");
        apb_write(8'h08, 32'hFFFF_FFFF);
        apb_read(8'h08, rd, err);
        expect_reg(32'h1, {31'h0, err}, "PSLVERR at 0x8");
        apb_read(flow_ctrl_pkg::CTRL_ADDR, rd, err);
        expect_reg(32'h0000_2B01, rd, "CTRL after bad write");

        send_frame(flow_ctrl_pkg::DT_RAW8, 2'd2, RAW8_BEATS, 0, 1'b0);
        send_frame(flow_ctrl_pkg::DT_RAW10, 2'd1, RAW10_BEATS, 3, 1'b1);
        send_frame(flow_ctrl_pkg::DT_RGB888, 2'd0, RGB_BEATS, 2, 1'b0);

        // Overflow with beats outside a frame, so nothing reaches the output
        stream_stall_i = 1'b1;
        for (int b = 0; b < OVF_BEATS; b++) begin
            take_bits(32, rd);
            byte_data_i  = {16'h0, rd} | 48'h1;
            byte_valid_i = 4'b0001;
            step_cycle();
        end
        byte_valid_i = '0;
        apb_read(flow_ctrl_pkg::STATUS_ADDR, rd, err);
        expect_reg(32'h1, rd, "STATUS after overflow");
        apb_write(flow_ctrl_pkg::STATUS_ADDR, 32'h1);
        apb_read(flow_ctrl_pkg::STATUS_ADDR, rd, err);
        expect_reg(32'h0, rd, "STATUS after clear");
        stream_stall_i = 1'b0;
        repeat (48) step_cycle();                            // Drain the buffer

        if (err_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run($sformatf("%0d checks failed", err_count));
        end
    end

endmodule
